// ==== files.f ====
hw/smc_xfer_pkg.sv
hw/smc_mem_pkg.sv
hw/smc_access_seq.sv
hw/smc_read_gather.sv
hw/smc_mac.sv
verification/tb_smc_mac.sv

// ==== verification/tb_smc_mac.sv ====
// multiple access controller testbench

`timescale 1ns/1ps

module tb_smc_mac;

  import smc_xfer_pkg::*;
  import smc_mem_pkg::*;

  localparam int NUM_XFERS      = 300;                 // random transfers
  localparam int TIMEOUT_CYCLES = NUM_XFERS * 10 + 50;  // worst case is 10 cycles each

  logic        sys_clk22;
  logic        n_sys_reset22;
  logic        valid_access;
  xfer_size_t  xfer_size;
  logic        smc_done;
  smc_state_t  smc_nextstate;
  logic        latch_data;
  mem_byte_t   data_smc;
  word_t       write_data;
  num_access_t r_num_access;
  logic        mac_done;
  xfer_size_t  v_xfer_size;
  mem_byte_t   smc_data;
  word_t       read_data;

  // expectations for the current cycle as set on the rising edge
  num_access_t exp_count;
  logic        exp_flag;
  xfer_size_t  exp_size;
  mem_byte_t   exp_byte;
  word_t       exp_word;
  logic        chk_word;   // read word valid to compare
  logic        checks_on;

  word_t       cur_wdata;  // write word on the bus right now
  logic [31:0] rng_state = 32'hf2b378d5;
  int          cycle_count = 0;
  int          num_checks = 0;
  int          err_word = 0;
  int          err_byte = 0;
  int          err_count = 0;
  int          err_size = 0;
  int          err_flag = 0;

  smc_mac i_dut
  (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .smc_data      (smc_data),
    .read_data     (read_data)
  );

  initial
  begin
    sys_clk22 = 1'b0;
    forever #50 sys_clk22 = ~sys_clk22;  // 100 ns period
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // remaining accesses after the first
  function automatic num_access_t load_count(input xfer_size_t sz);
    if (sz == XSIZ_8)
      return ACC_ONE;
    else if (sz == XSIZ_16)
      return ACC_TWO;
    return ACC_FOUR;
  endfunction

  // byte lane idx of a word with lane 3 on top
  function automatic mem_byte_t lane_byte(input word_t w, input num_access_t idx);
    return w[8*idx +: 8];
  endfunction

  // bytes packed in arrival order with the first in bits 31..24
  function automatic word_t expected_read(input xfer_size_t sz, input word_t bytes);
    case (sz)
      XSIZ_32: return bytes;
      XSIZ_16: return {bytes[31:16], bytes[31:16]};  // halfword twice
      default: return {4{bytes[31:24]}};             // one byte in every lane
    endcase
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  task automatic check_word(input string name, input word_t exp, input word_t act);
    num_checks++;
    if (act !== exp)
    begin
      err_word++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_byte(input string name, input mem_byte_t exp, input mem_byte_t act);
    num_checks++;
    if (act !== exp)
    begin
      err_byte++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_count(input string name, input num_access_t exp,
                             input num_access_t act);
    num_checks++;
    if (act !== exp)
    begin
      err_count++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_size(input string name, input xfer_size_t exp, input xfer_size_t act);
    num_checks++;
    if (act !== exp)
    begin
      err_size++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp)
    begin
      err_flag++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  // falling edge compare of all outputs
  always @(negedge sys_clk22)
  begin
    if (checks_on)
    begin
      check_count("r_num_access", exp_count, r_num_access);
      check_flag("mac_done", exp_flag, mac_done);
      check_size("v_xfer_size", exp_size, v_xfer_size);
      check_byte("smc_data", exp_byte, smc_data);
      if (chk_word)
        check_word("read_data", exp_word, read_data);
    end
  end

  always @(posedge sys_clk22)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run hung, no end of test after %0d cycles", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // memory controller emulation
  // ------------------------------------------------------------

  // count, flag, size and write byte for the cycle now starting
  task automatic set_expect(input num_access_t cnt, input xfer_size_t sz);
    exp_count <= cnt;
    exp_flag  <= (cnt == 2'd0);  // last access flag
    exp_size  <= sz;
    exp_byte  <= lane_byte(cur_wdata, cnt);
  endtask

  // stall adds one smc_done toward SMC_STORE before the first access
  task automatic run_transfer(input logic is_read, input xfer_size_t sz,
                              input word_t wd, input logic stall);
    num_access_t first;
    num_access_t cnt;
    word_t       rbytes;
    logic [31:0] rnd;
    mem_byte_t   b;
    int          n;
    first  = load_count(sz);
    n      = int'(first) + 1;
    rbytes = '0;
    b      = '0;
    @(posedge sys_clk22);  // address cycle
    valid_access  <= 1'b1;
    xfer_size     <= sz;
    smc_done      <= 1'b0;
    latch_data    <= 1'b0;
    smc_nextstate <= SMC_RW;
    chk_word      <= 1'b0;
    if (!is_read)
    begin
      cur_wdata = wd;
      write_data <= wd;
    end
    set_expect(ACC_ONE, sz);  // previous transfer left the count at 0
    for (int k = 0; k < n; k++)
    begin
      cnt = first - num_access_t'(k);
      next_random(rnd);
      if (stall && k == 0)
      begin
        @(posedge sys_clk22);
        valid_access <= 1'b0;
        xfer_size    <= rnd[1:0];  // junk since the size is stored by now
        set_expect(cnt, sz);
        @(posedge sys_clk22);
        smc_done      <= 1'b1;
        smc_nextstate <= SMC_STORE;  // count must hold
        set_expect(cnt, sz);
      end
      @(posedge sys_clk22);  // gap cycle
      valid_access <= 1'b0;
      xfer_size    <= rnd[9:8];
      smc_done     <= 1'b0;
      latch_data   <= 1'b0;
      set_expect(cnt, sz);
      b = rnd[7:0];
      @(posedge sys_clk22);  // access done
      smc_done      <= 1'b1;
      smc_nextstate <= (k == n - 1) ? SMC_IDLE : SMC_RW;
      latch_data    <= is_read;
      data_smc      <= b;
      set_expect(cnt, sz);
      rbytes[8*(3-k) +: 8] = b;
      if (is_read && k == n - 1)
      begin
        exp_word <= expected_read(sz, rbytes);
        chk_word <= 1'b1;  // live merge in the final latch
      end
    end
    @(posedge sys_clk22);  // idle cycle where the stored word must match
    smc_done      <= 1'b0;
    latch_data    <= 1'b0;
    smc_nextstate <= SMC_IDLE;
    data_smc      <= ~b;  // stale bus byte differs from the stored one
    set_expect(ACC_ONE, sz);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial
  begin
    logic [31:0] rnd;
    word_t       wd;
    xfer_size_t  sz;
    int          total;
    n_sys_reset22 <= 1'b0;
    valid_access  <= 1'b0;
    xfer_size     <= XSIZ_8;
    smc_done      <= 1'b0;
    smc_nextstate <= SMC_IDLE;
    latch_data    <= 1'b0;
    data_smc      <= '0;
    cur_wdata = 32'ha5c3_1e77;
    write_data    <= cur_wdata;
    exp_count     <= ACC_ONE;  // cleared counter after reset
    exp_flag      <= 1'b1;
    exp_size      <= XSIZ_8;
    exp_byte      <= cur_wdata[7:0];
    exp_word      <= '0;
    chk_word      <= 1'b0;
    checks_on     <= 1'b0;
    repeat (5) @(posedge sys_clk22);
    n_sys_reset22 <= 1'b1;
    checks_on     <= 1'b1;
    @(posedge sys_clk22);
    run_transfer(1'b0, XSIZ_32, 32'h1234_5678, 1'b1);  // stalled word write
    for (int i = 0; i < NUM_XFERS; i++)
    begin
      next_random(rnd);
      sz = xfer_size_t'(rnd[15:0] % 16'd3);  // reserved code left out
      next_random(wd);
      run_transfer(rnd[20], sz, wd, 1'b0);
    end
    repeat (2) @(posedge sys_clk22);
    total = err_word + err_byte + err_count + err_size + err_flag;
    $display("checks %0d errors %0d word %0d byte %0d count %0d size %0d flag %0d",
             num_checks, total, err_word, err_byte, err_count, err_size, err_flag);
    if (total == 0 && num_checks > 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== hw/smc_mac.sv ====
// multiple access controller top level

`timescale 1ns/1ps

module smc_mac
(
  input  logic                      sys_clk22,
  input  logic                      n_sys_reset22,
  input  logic                      valid_access,   // new transfer strobe
  input  smc_xfer_pkg::xfer_size_t  xfer_size,      // size of the new transfer
  input  logic                      smc_done,       // end of one memory access
  input  smc_mem_pkg::smc_state_t   smc_nextstate,  // memory controller next state
  input  logic                      latch_data,     // read byte valid
  input  smc_mem_pkg::mem_byte_t    data_smc,       // read byte from memory
  input  smc_xfer_pkg::word_t       write_data,     // write word from the bus
  output smc_xfer_pkg::num_access_t r_num_access,   // accesses still to come
  output logic                      mac_done,       // last access flag
  output smc_xfer_pkg::xfer_size_t  v_xfer_size,    // validated size
  output smc_mem_pkg::mem_byte_t    smc_data,       // write byte to memory
  output smc_xfer_pkg::word_t       read_data       // read word to the bus
);

  import smc_xfer_pkg::*;

  xfer_size_t r_xfer_size;  // stored size, sequencer to gatherer

  // ------------------------------------------------------------
  // input side
  // ------------------------------------------------------------

  smc_access_seq i_access_seq
  (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .write_data    (write_data),
    .r_xfer_size   (r_xfer_size),
    .v_xfer_size   (v_xfer_size),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .smc_data      (smc_data)
  );

  // ------------------------------------------------------------
  // read path
  // ------------------------------------------------------------

  // count picks the byte slot, size picks the word form
  smc_read_gather i_read_gather
  (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .r_num_access  (r_num_access),
    .r_xfer_size   (r_xfer_size),
    .read_data     (read_data)
  );

endmodule

// ==== hw/smc_read_gather.sv ====
// read data gatherer

`timescale 1ns/1ps

module smc_read_gather
(
  input  logic                      sys_clk22,
  input  logic                      n_sys_reset22,
  input  logic                      latch_data,    // data_smc holds a valid byte
  input  smc_mem_pkg::mem_byte_t    data_smc,      // byte from memory
  input  smc_xfer_pkg::num_access_t r_num_access,  // slot to fill
  input  smc_xfer_pkg::xfer_size_t  r_xfer_size,   // stored transfer size
  output smc_xfer_pkg::word_t       read_data      // word to the internal bus
);

  import smc_xfer_pkg::*;

  word_t r_read_data;  // bytes gathered so far

  // ------------------------------------------------------------
  // byte gathering
  // ------------------------------------------------------------

  // slot follows the write byte mapping, msb first
  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
    begin
      r_read_data <= '0;
    end
    else if (latch_data)
    begin
      case (r_num_access)
        2'd3:
        begin
          r_read_data[31:24] <= data_smc;  // first of four
          r_read_data[23:0]  <= 24'h0;
        end
        2'd2:
        begin
          r_read_data[23:16] <= data_smc;
          r_read_data[15:0]  <= 16'h0;     // top byte kept
        end
        2'd1:
        begin
          r_read_data[15:8] <= data_smc;
          r_read_data[7:0]  <= 8'h0;
        end
        default:
        begin
          r_read_data[7:0] <= data_smc;    // final byte
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // read word
  // ------------------------------------------------------------

  // the final byte is merged live so the bus sees it in the latch cycle
  always_comb
  begin
    case (r_xfer_size)
      XSIZ_32:
      begin
        if (latch_data)
        begin
          read_data = {r_read_data[31:8], data_smc};
        end
        else
        begin
          read_data = r_read_data;
        end
      end
      XSIZ_16:
      begin
        // halfword repeated on both halves
        if (latch_data)
        begin
          read_data = {(BYTES_PER_WORD/2){r_read_data[15:8], data_smc}};
        end
        else
        begin
          read_data = {(BYTES_PER_WORD/2){r_read_data[15:0]}};
        end
      end
      default:
      begin
        // byte and reserved sizes fill all lanes
        if (latch_data)
        begin
          read_data = {BYTES_PER_WORD{data_smc}};
        end
        else
        begin
          read_data = {BYTES_PER_WORD{r_read_data[7:0]}};
        end
      end
    endcase
  end

endmodule

// ==== hw/smc_access_seq.sv ====
// access sequencer for byte wide memory

`timescale 1ns/1ps

module smc_access_seq
(
  input  logic                     sys_clk22,
  input  logic                     n_sys_reset22,
  input  logic                     valid_access,   // address cycle of new transfer
  input  smc_xfer_pkg::xfer_size_t xfer_size,      // valid with valid_access only
  input  logic                     smc_done,       // end of one memory access
  input  smc_mem_pkg::smc_state_t  smc_nextstate,  // memory controller next state
  input  smc_xfer_pkg::word_t      write_data,     // held by the bus all transfer
  output smc_xfer_pkg::xfer_size_t r_xfer_size,    // stored size
  output smc_xfer_pkg::xfer_size_t v_xfer_size,    // live or stored size
  output smc_xfer_pkg::num_access_t r_num_access,  // accesses still to come
  output logic                     mac_done,       // last access of the transfer
  output smc_mem_pkg::mem_byte_t   smc_data        // byte to the memory bus
);

  import smc_xfer_pkg::*;
  import smc_mem_pkg::*;

  num_access_t num_accesses;  // counter load value for new size
  logic        access_step;   // completed access, more to follow

  // ------------------------------------------------------------
  // transfer size
  // ------------------------------------------------------------

  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
    begin
      r_xfer_size <= XSIZ_8;
    end
    else if (valid_access)
    begin
      r_xfer_size <= xfer_size;  // captured in the address cycle
    end
  end

  // live size during the address cycle, stored size after it
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  // ------------------------------------------------------------
  // access counter
  // ------------------------------------------------------------

  // number of byte accesses for the requested size
  always_comb
  begin
    case (xfer_size)
      XSIZ_8:
      begin
        num_accesses = ACC_ONE;
      end
      XSIZ_16:
      begin
        num_accesses = ACC_TWO;
      end
      default:
      begin
        num_accesses = ACC_FOUR;  // word and reserved codes
      end
    endcase
  end

  // idle and store mean the transfer ends or stalls here
  assign access_step = smc_done &&
                       (smc_nextstate != SMC_IDLE) &&
                       (smc_nextstate != SMC_STORE);

  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
    begin
      r_num_access <= ACC_ONE;
    end
    else if (valid_access)
    begin
      r_num_access <= num_accesses;  // new transfer wins
    end
    else if (access_step)
    begin
      r_num_access <= r_num_access - 2'd1;
    end
  end

  // count of zero marks the final access
  assign mac_done = (r_num_access == ACC_ONE);

  // ------------------------------------------------------------
  // write byte select
  // ------------------------------------------------------------

  // most significant byte goes out first
  always_comb
  begin
    case (r_num_access)
      2'd3:
      begin
        smc_data = write_data[31:24];
      end
      2'd2:
      begin
        smc_data = write_data[23:16];
      end
      2'd1:
      begin
        smc_data = write_data[15:8];
      end
      default:
      begin
        smc_data = write_data[7:0];  // last or only access
      end
    endcase
  end

endmodule

// ==== hw/smc_mem_pkg.sv ====
// external memory side definitions

package smc_mem_pkg;

  // ------------------------------------------------------------
  // memory data bus
  // ------------------------------------------------------------

  localparam int MEM_WIDTH = 8;  // external data bus is one byte

  typedef logic [MEM_WIDTH-1:0] mem_byte_t;  // one memory byte

  // ------------------------------------------------------------
  // memory controller states
  // ------------------------------------------------------------

  // one hot next state code from the memory controller
  typedef enum logic [4:0]
  {
    SMC_IDLE  = 5'b00001,  // no access in progress
    SMC_LE    = 5'b00010,  // address latch enable
    SMC_RW    = 5'b00100,  // read or write strobe
    SMC_STORE = 5'b01000,  // waiting on a stalled bus
    SMC_FLOAT = 5'b10000   // bus turnaround
  } smc_state_t;

endpackage

// ==== hw/smc_xfer_pkg.sv ====
// internal bus transfer definitions

package smc_xfer_pkg;

  // ------------------------------------------------------------
  // data word
  // ------------------------------------------------------------

  typedef logic [31:0] word_t;        // internal bus data word

  localparam int BYTES_PER_WORD = 4;  // byte lanes in one word

  // ------------------------------------------------------------
  // transfer size
  // ------------------------------------------------------------

  // size code from the address cycle
  typedef logic [1:0] xfer_size_t;

  localparam xfer_size_t XSIZ_8  = 2'd0;  // byte transfer
  localparam xfer_size_t XSIZ_16 = 2'd1;  // halfword transfer
  localparam xfer_size_t XSIZ_32 = 2'd2;  // word transfer
  // code 3 reserved, reads treat it as a byte

  // ------------------------------------------------------------
  // access count
  // ------------------------------------------------------------

  // accesses still to come after the current one
  typedef logic [1:0] num_access_t;

  localparam num_access_t ACC_ONE  = 2'd0;  // single access, last one
  localparam num_access_t ACC_TWO  = 2'd1;  // two byte accesses
  localparam num_access_t ACC_FOUR = 2'd3;  // four byte accesses

endpackage
